// File: tb/golden_stream.txt
// Each line {tag, word}: tag 01 burst input word, 0E expected burst output word,
// 02 wrap-around base word, 03 wrap-around word count, 04 back-pressure base word
01a5c3
0112f0
01ffff
010000
017e81
01c33c
010f1e
01b00b
0ea5c3
0e12f0
0effff
0e0000
0e7e81
0ec33c
0e0f1e
0eb00b
023c00
030030
04d100

// File: vlog.f
logic/sdramPkg.sv
logic/wordFifo.sv
logic/burstArbiter.sv
logic/burstSequencer.sv
logic/sdramFifoTop.sv
tb/sdramModel.sv
tb/sdramFifoTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sdramFifoTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/sdramFifoTb.sv
// ================================================
// SDRAM stream FIFO testbench
// Golden-file stimulus through the stream ports,
// in-order read-out checks, back-pressure, wrap
// and refresh checks against the SDRAM model
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdramFifoTb;

  logic                        CLK;
  logic                        RESET_N;
  logic [sdramPkg::DATA_W-1:0] inData;
  logic                        inValid;
  logic                        inReady;
  logic [sdramPkg::DATA_W-1:0] outData;
  logic                        outValid;
  logic                        outReady;
  sdramPkg::sdramCmd_t         sdramCmd;
  logic [sdramPkg::DATA_W-1:0] dqOut;
  logic                        dqOe;
  logic [sdramPkg::DATA_W-1:0] dqIn;
  int                          refreshCount;
  logic                        protoError;

  logic [23:0]                 golden [32];       // {tag, word} per line
  logic [sdramPkg::DATA_W-1:0] stimWords [$];     // Words of the current phase
  logic [sdramPkg::DATA_W-1:0] expectQ [$];       // Accepted, not yet read out
  integer                      inSeed;
  integer                      outSeed;
  int                          readyMode;         // 0 random gaps, 1 held low
  int                          cycleCount;        // Cycles since reset release
  int                          watchdogCycles;

  sdramFifoTop i_sdramFifoTop (.CLK, .RESET_N, .inData, .inValid, .inReady, .outData,
    .outValid, .outReady, .sdramCmd, .dqOut, .dqOe, .dqIn);

  sdramModel memModel (.CLK, .RESET_N, .sdramCmd, .dqOut, .dqOe, .dqIn, .refreshCount,
    .protoError);

  always #20 CLK = ~CLK;                          // 40 ns period

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  // Test word i of a generated phase, odd step keeps words distinct
  function automatic logic [sdramPkg::DATA_W-1:0] patternWord(
    input logic [sdramPkg::DATA_W-1:0] base, input int i);
    return base + 16'(i) * 16'h2f13;
  endfunction

  task automatic checkResetOutputs();
    assert (!outValid && !dqOe && !inReady && sdramCmd == sdramPkg::CMD_NOP)
    else abortRun($sformatf("[FAIL] %0t ns: outputs not idle around reset", $time));
  endtask

  // Called on a rising edge, returns on one
  task automatic sendWords(input bit queueExpected);
    int idx;
    idx = 0;
    while (idx < stimWords.size())
    begin
      inData  <= stimWords[idx];
      inValid <= ($random(inSeed) & 3) != 0;       // About one gap in four
      @(posedge CLK);
      if (inValid && inReady)
      begin
        if (queueExpected)
          expectQ.push_back(stimWords[idx]);
        idx++;
      end
    end
    inValid <= 1'b0;
  endtask

  // Push back-to-back until no word is taken for stallWindow cycles
  task automatic fillUntilStall(input int stallWindow, output int accepted);
    int idx;
    int idle;
    idx  = 0;
    idle = 0;
    while (idle < stallWindow && idx < stimWords.size())
    begin
      inData  <= stimWords[idx];
      inValid <= 1'b1;
      @(posedge CLK);
      if (inReady)
      begin
        expectQ.push_back(stimWords[idx]);
        idx++;
        idle = 0;
      end
      else
        idle++;
    end
    inValid  <= 1'b0;
    accepted = idx;
  endtask

  task automatic waitDrained();
    while (expectQ.size() != 0)
      @(posedge CLK);
  endtask

  // ================================================
  // Output stream checker and outReady driver
  // ================================================
  always @(posedge CLK)
  begin : outputMonitor
    logic readyGap;
    readyGap = ($random(outSeed) & 3) == 0;       // Drawn every cycle, one in four
    if (RESET_N)
    begin
      assert (!protoError)
      else abortRun("The SDRAM model saw an illegal command sequence");
      if (outValid && outReady)
      begin
        assert (expectQ.size() != 0)
        else abortRun("A word came out of the DUT that was never sent in");
        assert (outData == expectQ[0])
        else abortRun($sformatf("[FAIL] %0t ns: outData %h, expected %h",
                                $time, outData, expectQ[0]));
        void'(expectQ.pop_front());
      end
      cycleCount++;
    end
    if (readyMode == 1)
      outReady <= 1'b0;
    else
      outReady <= !readyGap;
  end

  initial
  begin : watchdog
    @(posedge RESET_N);
    repeat (watchdogCycles) @(posedge CLK);
    abortRun("Watchdog expired before the tests finished, the data stream seems stuck");
  end

  initial
  begin : mainFlow
    logic [sdramPkg::DATA_W-1:0] wrapBase;
    logic [sdramPkg::DATA_W-1:0] bpBase;
    int                          wrapCount;
    int                          capacity;
    int                          stallWindow;
    int                          accepted;

    inSeed     = 32'h84c0;
    outSeed    = inSeed + 1;                      // Own stream for outReady gaps
    CLK        = 1'b0;
    RESET_N    = 1'b0;
    inData     = '0;
    inValid    = 1'b0;
    outReady   = 1'b0;
    readyMode  = 0;
    cycleCount = 0;
    wrapBase   = '0;
    bpBase     = '0;
    wrapCount  = 0;
    accepted   = 0;

    for (int i = 0; i < 32; i++)
      golden[i] = '0;                             // Tag 00 marks an unused entry
    $readmemh("tb/golden_stream.txt", golden);
    for (int i = 0; i < 32; i++)
      case (golden[i][23:16])
        8'h01: stimWords.push_back(golden[i][15:0]);
        8'h0e: expectQ.push_back(golden[i][15:0]);
        8'h02: wrapBase = golden[i][15:0];
        8'h03: wrapCount = int'(golden[i][15:0]);
        8'h04: bpBase = golden[i][15:0];
        default: ;
      endcase
    assert (stimWords.size() == sdramPkg::BURST_LEN && expectQ.size() == sdramPkg::BURST_LEN
            && wrapCount % sdramPkg::BURST_LEN == 0
            && wrapCount > sdramPkg::REGION_BURSTS * sdramPkg::BURST_LEN)
    else abortRun("The golden file does not describe the expected test phases");

    capacity = 2 * sdramPkg::FIFO_DEPTH + sdramPkg::REGION_BURSTS * sdramPkg::BURST_LEN;
    stallWindow = 4 * (sdramPkg::T_RCD + sdramPkg::BURST_LEN + sdramPkg::CAS_LAT +
                       sdramPkg::T_RP + sdramPkg::T_RFC);    // Several bursts plus a refresh
    watchdogCycles = (2 * sdramPkg::BURST_LEN + wrapCount + capacity) *
                     2 * sdramPkg::REFRESH_INTERVAL;

    // Reset, 2 cycles low, checked in the last reset cycle and the one after
    @(posedge CLK);
    @(posedge CLK);
    checkResetOutputs();
    RESET_N <= 1'b1;
    @(posedge CLK);
    checkResetOutputs();

    // Single burst, expected words straight from the file
    sendWords(1'b0);
    waitDrained();

    // Wrap-around, more words than the region holds
    stimWords.delete();
    for (int i = 0; i < wrapCount; i++)
      stimWords.push_back(patternWord(wrapBase, i));
    sendWords(1'b1);
    waitDrained();

    // Back-pressure, outReady held low until the input stalls
    readyMode = 1;
    stimWords.delete();
    for (int i = 0; i < capacity + sdramPkg::BURST_LEN; i++)
      stimWords.push_back(patternWord(bpBase, i));
    fillUntilStall(stallWindow, accepted);
    assert (accepted >= 2 * sdramPkg::FIFO_DEPTH && accepted <= capacity && !inReady)
    else abortRun($sformatf(
      "[FAIL] %0t ns: %0d words taken under back-pressure, expected %0d to %0d",
      $time, accepted, 2 * sdramPkg::FIFO_DEPTH, capacity));
    readyMode = 0;
    waitDrained();

    // Long enough for several refresh intervals
    while (cycleCount <= 4 * sdramPkg::REFRESH_INTERVAL + sdramPkg::INIT_WAIT)
      @(posedge CLK);
    assert (refreshCount >= 3)
    else abortRun($sformatf("[FAIL] %0t ns: %0d refreshes after init, expected at least 3",
                            $time, refreshCount));

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/sdramModel.sv
// ================================================
// Behavioural SDRAM model
// Decodes pin commands, stores written words,
// returns read data after CAS latency and flags
// illegal command sequences
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdramModel (
  input  logic                        CLK,
  input  logic                        RESET_N,
  input  sdramPkg::sdramCmd_t         sdramCmd,
  input  logic [sdramPkg::DATA_W-1:0] dqOut,
  input  logic                        dqOe,
  output logic [sdramPkg::DATA_W-1:0] dqIn,
  output int                          refreshCount,   // REFRESH after the mode load
  output logic                        protoError      // Sticky
);

  logic [sdramPkg::DATA_W-1:0]    mem [int];          // Sparse, keyed by {bank,row,col}
  logic [sdramPkg::ROW_W-1:0]     openRow [2**sdramPkg::BANK_W];
  logic [2**sdramPkg::BANK_W-1:0] rowOpen;
  int                             sinceAct [2**sdramPkg::BANK_W];
  logic [sdramPkg::DATA_W-1:0]    rdPipe [sdramPkg::CAS_LAT];  // Read return delay
  logic                           modeLoaded;
  logic [3:0]                     code;
  logic                           isNop, isAct, isRead, isWrite, isPre, isRef, isMode;
  int                             wordAddr;

  // {csN, rasN, casN, weN} of a pin command
  function automatic logic [3:0] cmdCode(input sdramPkg::sdramCmd_t c);
    return {c.csN, c.rasN, c.casN, c.weN};
  endfunction

  assign code     = cmdCode(sdramCmd);
  assign isNop    = (code == cmdCode(sdramPkg::CMD_NOP));
  assign isAct    = (code == cmdCode(sdramPkg::CMD_ACTIVE));
  assign isRead   = (code == cmdCode(sdramPkg::CMD_READ));
  assign isWrite  = (code == cmdCode(sdramPkg::CMD_WRITE));
  assign isPre    = (code == cmdCode(sdramPkg::CMD_PRECHARGE));
  assign isRef    = (code == cmdCode(sdramPkg::CMD_REFRESH));
  assign isMode   = (code == cmdCode(sdramPkg::CMD_MODE));
  assign wordAddr = int'({sdramCmd.ba, openRow[sdramCmd.ba],
                          sdramCmd.addr[sdramPkg::COL_W-1:0]});
  assign dqIn     = rdPipe[sdramPkg::CAS_LAT-1];      // Stable at the CAS_LAT-th edge

  always @(posedge CLK or negedge RESET_N)
  begin : decode
    string fault;
    fault = "";
    if (!RESET_N)
    begin
      rowOpen      <= '0;
      modeLoaded   <= 1'b0;
      refreshCount <= 0;
      protoError   <= 1'b0;
      for (int b = 0; b < 2**sdramPkg::BANK_W; b++)
      begin
        sinceAct[b] <= 0;
        openRow[b]  <= '0;
      end
      for (int s = 0; s < sdramPkg::CAS_LAT; s++)
        rdPipe[s] <= '0;
    end
    else
    begin
      for (int s = 1; s < sdramPkg::CAS_LAT; s++)
        rdPipe[s] <= rdPipe[s-1];
      rdPipe[0] <= '0;
      for (int b = 0; b < 2**sdramPkg::BANK_W; b++)
        if (sinceAct[b] < 1000)
          sinceAct[b] <= sinceAct[b] + 1;             // Saturating age
      if (!modeLoaded && !(isNop || isPre || isRef || isMode))
        fault = "SDRAM model: a command other than NOP, PRECHARGE, REFRESH or MODE before mode load";
      if (isAct)
      begin
        if (rowOpen[sdramCmd.ba])
          fault = "SDRAM model: ACTIVE to a bank whose row is still open";
        rowOpen[sdramCmd.ba]  <= 1'b1;
        openRow[sdramCmd.ba]  <= sdramCmd.addr;
        sinceAct[sdramCmd.ba] <= 1;                   // Reads k at the k-th later edge
      end
      if (isRead || isWrite)
      begin
        if (!rowOpen[sdramCmd.ba])
          fault = "SDRAM model: a column command targets a closed row";
        else if (sinceAct[sdramCmd.ba] < sdramPkg::T_RCD)
          fault = "SDRAM model: a column command came within T_RCD of its ACTIVE";
        if (isWrite)
        begin
          if (!dqOe)
            fault = "SDRAM model: WRITE without the data bus driven";
          mem[wordAddr] = dqOut;
        end
        else if (!mem.exists(wordAddr))
          fault = "SDRAM model: READ of a word that was never written";
        else
          rdPipe[0] <= mem[wordAddr];
      end
      if (isPre)
      begin
        if (sdramCmd.addr[10])
          rowOpen <= '0;                              // A10 high closes all banks
        else
          rowOpen[sdramCmd.ba] <= 1'b0;
      end
      if (isRef)
      begin
        if (rowOpen != '0)
          fault = "SDRAM model: REFRESH while a row is open";
        if (modeLoaded)
          refreshCount <= refreshCount + 1;
      end
      if (isMode)
        modeLoaded <= 1'b1;
      if (fault != "")
      begin
        $display("%s", fault);
        protoError <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sdramFifoTop.sv
// ================================================
// SDRAM stream FIFO top
// Write FIFO, SDRAM bursts and read FIFO between
// two valid/ready stream ports
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdramFifoTop (
  input  logic                        CLK,
  input  logic                        RESET_N,
  input  logic [sdramPkg::DATA_W-1:0] inData,
  input  logic                        inValid,
  output logic                        inReady,
  output logic [sdramPkg::DATA_W-1:0] outData,
  output logic                        outValid,
  input  logic                        outReady,
  output sdramPkg::sdramCmd_t         sdramCmd,
  output logic [sdramPkg::DATA_W-1:0] dqOut,
  output logic                        dqOe,
  input  logic [sdramPkg::DATA_W-1:0] dqIn
);

  logic [sdramPkg::DATA_W-1:0] wrHead;          // Write FIFO head to DQ
  logic [sdramPkg::DATA_W-1:0] rdData;          // Returned SDRAM word
  logic [sdramPkg::FILL_W-1:0] wrFill;
  logic [sdramPkg::FILL_W-1:0] rdFill;
  logic                        wrFull;
  logic                        rdEmpty;
  logic                        wrPop;
  logic                        rdPush;
  logic                        reqValid;
  logic                        reqAccept;
  logic                        burstDone;
  sdramPkg::burstReq_t         burstReq;

  // Stream handshakes
  assign inReady  = !wrFull;
  assign outValid = !rdEmpty;

  wordFifo wrFifo (.CLK, .RESET_N, .pushData(inData), .push(inValid && inReady),
    .pop(wrPop), .popData(wrHead), .full(wrFull), .empty(), .fillCount(wrFill));

  wordFifo rdFifo (.CLK, .RESET_N, .pushData(rdData), .push(rdPush),
    .pop(outValid && outReady), .popData(outData), .full(), .empty(rdEmpty),
    .fillCount(rdFill));

  burstArbiter arbiter (.CLK, .RESET_N, .wrFill, .rdFill, .burstDone, .reqAccept,
    .burstReq, .reqValid);

  burstSequencer sequencer (.CLK, .RESET_N, .burstReq, .reqValid, .wrData(wrHead), .dqIn,
    .reqAccept, .burstDone, .wrPop, .rdPush, .rdData, .sdramCmd, .dqOut, .dqOe);

endmodule

`default_nettype wire

// File: logic/burstSequencer.sv
// ================================================
// SDRAM burst sequencer
// Power-up init, auto-refresh and page-mode bursts
// of BURST_LEN column commands, registered pins
// ================================================
`timescale 1ns/1ps
`default_nettype none

module burstSequencer (
  input  logic                        CLK,
  input  logic                        RESET_N,
  input  sdramPkg::burstReq_t         burstReq,
  input  logic                        reqValid,
  input  logic [sdramPkg::DATA_W-1:0] wrData,
  input  logic [sdramPkg::DATA_W-1:0] dqIn,
  output logic                        reqAccept,
  output logic                        burstDone,
  output logic                        wrPop,
  output logic                        rdPush,
  output logic [sdramPkg::DATA_W-1:0] rdData,
  output sdramPkg::sdramCmd_t         sdramCmd,
  output logic [sdramPkg::DATA_W-1:0] dqOut,
  output logic                        dqOe
);

  typedef enum logic [3:0] {
    S_INIT, S_INIT_PRE, S_INIT_REF, S_MODE, S_IDLE,
    S_REFRESH, S_ACTIVE, S_COL, S_DRAIN, S_PRECH
  } seqState_t;

  seqState_t                     state;
  logic [sdramPkg::WAIT_W-1:0]   waitCnt;      // Shared down counter
  logic [sdramPkg::REF_W-1:0]    refTimer;
  logic                          refPending;
  logic                          secondRef;    // Init refresh two under way
  logic                          curWrite;
  logic [sdramPkg::BANK_W-1:0]   curBank;
  logic [sdramPkg::COL_W-1:0]    curCol;       // Starting column
  logic [sdramPkg::BEAT_W-1:0]   colCnt;
  logic [sdramPkg::CAS_LAT:0]    rdPipe;       // Read beats in flight
  logic [sdramPkg::ADDR_W-1:0]   reqAddr;
  logic                          waitDone;
  logic                          refTake;
  logic                          colRead;
  logic                          cmdIsPre;
  logic                          cmdIsAct;
  sdramPkg::sdramCmd_t           actCmd;
  sdramPkg::sdramCmd_t           colCmd;

  assign waitDone  = (waitCnt == '0);
  assign refTake   = (state == S_IDLE) && refPending;   // Refresh beats a new request
  assign reqAccept = (state == S_IDLE) && !refPending && reqValid;
  assign burstDone = (state == S_PRECH) && waitDone;
  assign wrPop     = (state == S_COL) && curWrite;      // Head word goes out with WRITE
  assign colRead   = (state == S_COL) && !curWrite;
  assign rdPush    = rdPipe[sdramPkg::CAS_LAT];
  assign rdData    = dqIn;      // Valid CAS_LAT cycles after READ is on the pins
  assign reqAddr   = sdramPkg::ADDR_W'(burstReq.burstAddr) << sdramPkg::BEAT_W;

  always_comb
  begin
    actCmd      = sdramPkg::CMD_ACTIVE;
    actCmd.ba   = reqAddr[sdramPkg::COL_W + sdramPkg::ROW_W +: sdramPkg::BANK_W];
    actCmd.addr = reqAddr[sdramPkg::COL_W +: sdramPkg::ROW_W];
    colCmd      = curWrite ? sdramPkg::CMD_WRITE : sdramPkg::CMD_READ;
    colCmd.ba   = curBank;
    colCmd.addr = sdramPkg::ROW_W'(curCol + sdramPkg::COL_W'(colCnt));  // A10 low
  end

  // ================================================
  // Command FSM
  // ================================================
  // Waits that end in a command load N-1, waits that hand over to
  // an issuing state load N-2
  always_ff @(posedge CLK or negedge RESET_N)
    if (!RESET_N)
    begin
      state     <= S_INIT;
      waitCnt   <= sdramPkg::WAIT_W'(sdramPkg::INIT_WAIT - 1);
      secondRef <= 1'b0;
      curWrite  <= 1'b0;
      curBank   <= '0;
      curCol    <= '0;
      colCnt    <= '0;
      sdramCmd  <= sdramPkg::CMD_NOP;
      dqOe      <= 1'b0;
    end
    else
    begin
      sdramCmd <= sdramPkg::CMD_NOP;           // Default NOP, DQM high
      dqOe     <= 1'b0;
      if (!waitDone)
        waitCnt <= waitCnt - 1'b1;
      case (state)
        S_INIT:
          if (waitDone)
          begin
            sdramCmd <= sdramPkg::CMD_PRECHARGE;
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_RP - 1);
            state    <= S_INIT_PRE;
          end
        S_INIT_PRE:
          if (waitDone)
          begin
            sdramCmd <= sdramPkg::CMD_REFRESH;
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_RFC - 1);
            state    <= S_INIT_REF;
          end
        S_INIT_REF:
          if (waitDone && !secondRef)
          begin
            sdramCmd  <= sdramPkg::CMD_REFRESH;
            waitCnt   <= sdramPkg::WAIT_W'(sdramPkg::T_RFC - 1);
            secondRef <= 1'b1;
          end
          else if (waitDone)
          begin
            sdramCmd <= sdramPkg::CMD_MODE;
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_MRD - 2);
            state    <= S_MODE;
          end
        S_MODE, S_REFRESH:
          if (waitDone)
            state <= S_IDLE;
        S_IDLE:
          if (refTake)
          begin
            sdramCmd <= sdramPkg::CMD_REFRESH;
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_RFC - 2);
            state    <= S_REFRESH;
          end
          else if (reqAccept)
          begin
            sdramCmd <= actCmd;                // Open the row
            curWrite <= burstReq.isWrite;
            curBank  <= actCmd.ba;
            curCol   <= reqAddr[sdramPkg::COL_W-1:0];
            colCnt   <= '0;
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_RCD - 2);
            state    <= S_ACTIVE;
          end
        S_ACTIVE:
          if (waitDone)
            state <= S_COL;
        S_COL:
        begin
          sdramCmd <= colCmd;                  // One column per cycle
          dqOe     <= curWrite;
          colCnt   <= colCnt + 1'b1;
          if (colCnt == sdramPkg::BEAT_W'(sdramPkg::BURST_LEN - 1))
          begin
            // Write recovery, or wait out the last read beat
            waitCnt <= curWrite ? sdramPkg::WAIT_W'(sdramPkg::T_RCD - 1)
                                : sdramPkg::WAIT_W'(sdramPkg::CAS_LAT);
            state   <= S_DRAIN;
          end
        end
        S_DRAIN:
          if (waitDone)
          begin
            sdramCmd <= sdramPkg::CMD_PRECHARGE;   // Also ends the full-page burst
            waitCnt  <= sdramPkg::WAIT_W'(sdramPkg::T_RP - 2);
            state    <= S_PRECH;
          end
        S_PRECH:
          if (waitDone)
            state <= S_IDLE;
        default:
          state <= S_INIT;
      endcase
    end

  // ================================================
  // Refresh timer and read return pipe
  // ================================================
  always_ff @(posedge CLK or negedge RESET_N)
    if (!RESET_N)
    begin
      refTimer   <= sdramPkg::REF_W'(sdramPkg::REFRESH_INTERVAL - 1);
      refPending <= 1'b0;
      rdPipe     <= '0;
    end
    else
    begin
      if (refTake)
        refPending <= 1'b0;
      if (refTimer == '0)
      begin
        refTimer   <= sdramPkg::REF_W'(sdramPkg::REFRESH_INTERVAL - 1);
        refPending <= 1'b1;                    // Served at the next idle
      end
      else
        refTimer <= refTimer - 1'b1;
      rdPipe <= {rdPipe[sdramPkg::CAS_LAT-1:0], colRead};
    end

  always_ff @(posedge CLK)
    if (wrPop)
      dqOut <= wrData;

  assign cmdIsPre = !sdramCmd.csN && !sdramCmd.rasN && sdramCmd.casN && !sdramCmd.weN;
  assign cmdIsAct = !sdramCmd.csN && !sdramCmd.rasN && sdramCmd.casN && sdramCmd.weN;

  // Row stays closed for T_RP after PRECHARGE
  aPrechargeGap: assert property (@(posedge CLK) disable iff (!RESET_N)
    cmdIsPre |=> !cmdIsAct [* sdramPkg::T_RP - 1]);

endmodule

`default_nettype wire

// File: logic/burstArbiter.sv
// ================================================
// Burst arbiter
// Picks the next write or read burst, keeps the
// wrapping burst pointers and the stored count
// ================================================
`timescale 1ns/1ps
`default_nettype none

module burstArbiter (
  input  logic                        CLK,
  input  logic                        RESET_N,
  input  logic [sdramPkg::FILL_W-1:0] wrFill,
  input  logic [sdramPkg::FILL_W-1:0] rdFill,
  input  logic                        burstDone,
  input  logic                        reqAccept,
  output sdramPkg::burstReq_t         burstReq,
  output logic                        reqValid
);

  logic [sdramPkg::BADDR_W-1:0] wrPtr;
  logic [sdramPkg::BADDR_W-1:0] rdPtr;
  logic [sdramPkg::BADDR_W:0]   storedCount;   // Bursts held in SDRAM
  logic                         busy;          // One burst outstanding
  logic                         wrDue;
  logic                         rdDue;

  // Next burst slot, wraps at the region end
  function automatic logic [sdramPkg::BADDR_W-1:0] wrapInc(
    input logic [sdramPkg::BADDR_W-1:0] ptr);
    if (ptr == sdramPkg::BADDR_W'(sdramPkg::REGION_BURSTS - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // Writes first, as long as the region has room
  assign wrDue = (wrFill >= sdramPkg::FILL_W'(sdramPkg::BURST_LEN)) &&
                 (storedCount < (sdramPkg::BADDR_W + 1)'(sdramPkg::REGION_BURSTS));
  assign rdDue = (storedCount != '0) &&
                 (rdFill <= sdramPkg::FILL_W'(sdramPkg::FIFO_DEPTH - sdramPkg::BURST_LEN));

  always_ff @(posedge CLK or negedge RESET_N)
    if (!RESET_N)
    begin
      reqValid    <= 1'b0;
      busy        <= 1'b0;
      burstReq    <= '0;
      wrPtr       <= '0;
      rdPtr       <= '0;
      storedCount <= '0;
    end
    else
    begin
      if (reqAccept)
        reqValid <= 1'b0;                      // Held stable until taken
      if (!busy && (wrDue || rdDue))
      begin
        busy               <= 1'b1;
        reqValid           <= 1'b1;
        burstReq.isWrite   <= wrDue;
        burstReq.burstAddr <= wrDue ? wrPtr : rdPtr;
      end
      if (burstDone)
      begin
        busy <= 1'b0;
        if (burstReq.isWrite)
        begin
          wrPtr       <= wrapInc(wrPtr);
          storedCount <= storedCount + 1'b1;
        end
        else
        begin
          rdPtr       <= wrapInc(rdPtr);
          storedCount <= storedCount - 1'b1;
        end
      end
    end

  aStoredBound: assert property (@(posedge CLK) disable iff (!RESET_N)
    storedCount <= (sdramPkg::BADDR_W + 1)'(sdramPkg::REGION_BURSTS));

endmodule

`default_nettype wire

// File: logic/wordFifo.sv
// ================================================
// Word FIFO
// Single-clock register-array FIFO with fill count
// and registered full / empty flags
// ================================================
`timescale 1ns/1ps
`default_nettype none

module wordFifo (
  input  logic                        CLK,
  input  logic                        RESET_N,
  input  logic [sdramPkg::DATA_W-1:0] pushData,
  input  logic                        push,
  input  logic                        pop,
  output logic [sdramPkg::DATA_W-1:0] popData,
  output logic                        full,
  output logic                        empty,
  output logic [sdramPkg::FILL_W-1:0] fillCount
);

  logic [sdramPkg::DATA_W-1:0] mem [sdramPkg::FIFO_DEPTH];
  logic [sdramPkg::PTR_W-1:0]  wrPtr;
  logic [sdramPkg::PTR_W-1:0]  rdPtr;
  logic [sdramPkg::FILL_W-1:0] nextCount;

  assign nextCount = fillCount + sdramPkg::FILL_W'(push) - sdramPkg::FILL_W'(pop);
  assign popData = mem[rdPtr];                 // Head word, no read latency

  always_ff @(posedge CLK)
    if (push)
      mem[wrPtr] <= pushData;

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge CLK or negedge RESET_N)
    if (!RESET_N)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
      full      <= 1'b1;                       // Port closed until after reset
      empty     <= 1'b1;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      fillCount <= nextCount;
      full      <= (nextCount == sdramPkg::FILL_W'(sdramPkg::FIFO_DEPTH));
      empty     <= (nextCount == '0);
    end

  // Callers gate push and pop with the flags
  aNoOverflow: assert property (@(posedge CLK) disable iff (!RESET_N) push |-> !full);
  aNoUnderflow: assert property (@(posedge CLK) disable iff (!RESET_N) pop |-> !empty);

endmodule

`default_nettype wire

// File: logic/sdramPkg.sv
// ================================================
// SDRAM stream FIFO shared definitions
// Geometry, burst sizing, SDRAM timing, the pin
// command encoding and the arbiter request
// ================================================
`default_nettype none

package sdramPkg;

  // Geometry
  localparam int DATA_W = 16;
  localparam int ROW_W = 12;                   // Also the pin address width
  localparam int COL_W = 8;
  localparam int BANK_W = 2;
  localparam int ADDR_W = BANK_W + ROW_W + COL_W;   // Flat word address {bank,row,col}

  // Bursts, region and FIFOs
  localparam int BURST_LEN = 8;
  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam int REGION_BURSTS = 4;            // 32-word wrapping region
  localparam int BADDR_W = $clog2(REGION_BURSTS);
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int FILL_W = PTR_W + 1;

  // Timing, all in CLK cycles
  localparam int CAS_LAT = 3;
  localparam int T_RCD = 3;
  localparam int T_RP = 3;
  localparam int T_RFC = 7;
  localparam int T_MRD = 2;                    // Mode load to next command
  localparam int REFRESH_INTERVAL = 390;
  localparam int INIT_WAIT = 100;
  localparam int WAIT_W = $clog2(INIT_WAIT);   // Widest wait is power-up
  localparam int REF_W = $clog2(REFRESH_INTERVAL);

  // Write burst as programmed, op mode std, CAS 3, sequential, full page
  localparam logic [ROW_W-1:0] MODE_WORD = {2'b00, 1'b0, 2'b00, 3'b011, 1'b0, 3'b111};

  // Full pin command
  typedef struct packed {
    logic              csN;
    logic              rasN;
    logic              casN;
    logic              weN;
    logic [BANK_W-1:0] ba;
    logic [ROW_W-1:0]  addr;
    logic [1:0]        dqm;
  } sdramCmd_t;

  // Order csN, rasN, casN, weN, ba, addr, dqm
  localparam sdramCmd_t CMD_NOP       = '{1'b0, 1'b1, 1'b1, 1'b1, '0, '0, 2'b11};
  localparam sdramCmd_t CMD_ACTIVE    = '{1'b0, 1'b0, 1'b1, 1'b1, '0, '0, 2'b11};
  localparam sdramCmd_t CMD_READ      = '{1'b0, 1'b1, 1'b0, 1'b1, '0, '0, 2'b00};
  localparam sdramCmd_t CMD_WRITE     = '{1'b0, 1'b1, 1'b0, 1'b0, '0, '0, 2'b00};
  localparam sdramCmd_t CMD_PRECHARGE = '{1'b0, 1'b0, 1'b1, 1'b0, '0, 12'h400, 2'b11};  // All banks
  localparam sdramCmd_t CMD_REFRESH   = '{1'b0, 1'b0, 1'b0, 1'b1, '0, '0, 2'b11};
  localparam sdramCmd_t CMD_MODE      = '{1'b0, 1'b0, 1'b0, 1'b0, '0, MODE_WORD, 2'b11};

  // Arbiter request, burst index into the region
  typedef struct packed {
    logic               isWrite;
    logic [BADDR_W-1:0] burstAddr;
  } burstReq_t;

endpackage

`default_nettype wire
